// File: files.f
+incdir+include
logic/i2cm_pkg.sv
logic/i2cm_byte_sequencer.sv
logic/i2cm_bit_engine.sv
logic/i2cm_read_collect.sv
logic/i2cm_top.sv
testbench/i2cm_props.sv
testbench/i2cm_checker.sv
testbench/i2cm_tb.sv

// File: Bender.yml
package:
  name: i2cm

sources:
  - include_dirs:
      - include
    files:
      - logic/i2cm_pkg.sv
      - logic/i2cm_byte_sequencer.sv
      - logic/i2cm_bit_engine.sv
      - logic/i2cm_read_collect.sv
      - logic/i2cm_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/i2cm_props.sv
      - testbench/i2cm_checker.sv
      - testbench/i2cm_tb.sv

// File: testbench/i2cm_tb.sv
// testbench of the i2c master: clock, reset, random transactions,
// an i2c slave model on the enables and the run timeout
`timescale 1ns/1ns
`include "i2cm_settings.svh"

module i2cm_tb;

   localparam int N_TXN       = 40;
   localparam int RST_CYC     = 10;
   localparam int GAP_CYC     = 4;
   localparam int MAX_TXN_CYC = (3 + 2 + 4) * 37 + 27;   // read, 16-bit addr, 4 bytes
   localparam int TIMEOUT_CYC = N_TXN * (MAX_TXN_CYC + GAP_CYC) + 100 + RST_CYC;

   logic                       i2c_clk;
   logic                       i2c_rst_n;
   logic                       i_trg;
   logic [6:0]                 i_dev_id;
   logic                       i_addr16;
   logic [`I2CM_ADDR_WID-1:0]  i_addr;
   logic [`I2CM_NUM_WID-1:0]   i_num;
   logic                       i_rd;
   logic [`I2CM_BYTE_BITS-1:0] i_wr_data;
   logic                       o_scl_en;
   logic                       o_sda_en;
   logic                       o_wr_req;
   logic                       o_rd_vld;
   logic                       o_done;
   logic                       o_nack;
   logic [`I2CM_BYTE_BITS-1:0] o_rd_data;
   logic [`I2CM_ADDR_WID-1:0]  o_data_addr;
   wire                        scl_line;
   wire                        sda_line;
   integer                     seed;
   logic [31:0]                rnd;
   int                         cycle_cnt = 0;
   int                         err_total;

   // slave model state
   logic [7:0]                 slv_mem [logic [15:0]];
   logic                       slv_sda_rel = 1'b1;    // 0 pulls sda low
   logic                       cur_addr16 = 1'b0;     // address width the slave expects
   int                         bit_cnt = 0;           // bits of the current 9-bit frame
   int                         byte_idx = 0;          // bytes since the last start
   int                         slv_acks = 0;
   int                         slv_nacks = 0;
   logic [7:0]                 shreg;
   logic [7:0]                 tx_data;
   logic [15:0]                ptr;
   logic                       in_txn = 1'b0;
   logic                       selected = 1'b0;
   logic                       rd_dir = 1'b0;
   logic                       tx_active = 1'b0;      // slave is sending read data
   logic                       m_acked = 1'b0;

   assign scl_line = o_scl_en;                       // no clock stretching
   assign sda_line = o_sda_en & slv_sda_rel;

   i2cm_top i_i2cm_top (
      .i2c_clk(i2c_clk), .i2c_rst_n(i2c_rst_n), .i_trg(i_trg), .i_dev_id(i_dev_id),
      .i_addr16(i_addr16), .i_addr(i_addr), .i_num(i_num), .i_rd(i_rd),
      .i_wr_data(i_wr_data), .i_sda(sda_line), .o_scl_en(o_scl_en), .o_sda_en(o_sda_en),
      .o_wr_req(o_wr_req), .o_rd_data(o_rd_data), .o_rd_vld(o_rd_vld),
      .o_data_addr(o_data_addr), .o_done(o_done), .o_nack(o_nack)
   );

   i2cm_checker i_checker (
      .i2c_clk(i2c_clk), .i2c_rst_n(i2c_rst_n), .i_trg(i_trg), .i_dev_id(i_dev_id),
      .i_addr16(i_addr16), .i_addr(i_addr), .i_num(i_num), .i_rd(i_rd),
      .i_wr_data(i_wr_data), .i_scl_en(o_scl_en), .i_sda_en(o_sda_en),
      .i_wr_req(o_wr_req), .i_rd_data(o_rd_data), .i_rd_vld(o_rd_vld),
      .i_data_addr(o_data_addr), .i_done(o_done), .i_nack(o_nack),
      .i_slv_acks(slv_acks), .i_slv_nacks(slv_nacks),
      .i_assert_fails(i_i2cm_top.i_i2cm_bit_engine.i_props.fail_cnt),
      .o_err_total(err_total)
   );

   bind i2cm_bit_engine i2cm_props i_props (
      .i2c_clk(i2c_clk), .i2c_rst_n(i2c_rst_n), .i_scl_en(o_scl_en), .i_sda_en(o_sda_en),
      .i_busy(busy), .i_op(op_q), .i_op_go(i_op_go), .i_op_done(o_op_done)
   );

   // content of a register never written
   function automatic logic [7:0] fill_value(input logic [15:0] a);
      return a[7:0] ^ {a[14:8], a[15]} ^ 8'hA5;
   endfunction

   task automatic load_rd_byte();
      if (!slv_mem.exists(ptr)) slv_mem[ptr] = fill_value(ptr);
      tx_data = slv_mem[ptr];
      ptr     = ptr + 1'b1;
   endtask

   // a byte from the master, returns the ack decision
   task automatic take_byte(input logic [7:0] b, output logic ack);
      int a_bytes;
      a_bytes = cur_addr16 ? 2 : 1;
      ack     = 1'b0;
      if (byte_idx == 0) begin
         selected = (b[7:1] == 7'h50);
         rd_dir   = b[0];
         ack      = selected;
      end else if (selected && !rd_dir) begin
         ack = 1'b1;
         if (byte_idx <= a_bytes) begin
            if (!cur_addr16) ptr = {8'h00, b};
            else if (byte_idx == 1) ptr[15:8] = b;
            else ptr[7:0] = b;
         end else begin
            slv_mem[ptr] = b;
            ptr          = ptr + 1'b1;
         end
      end
      byte_idx++;
   endtask

   always @(negedge sda_line) begin
      if (scl_line === 1'b1) begin                  // start or repeated start
         if (!in_txn) begin
            slv_acks  = 0;
            slv_nacks = 0;
         end
         in_txn      = 1'b1;
         bit_cnt     = 0;
         byte_idx    = 0;
         selected    = 1'b0;
         tx_active   = 1'b0;
         slv_sda_rel = 1'b1;
      end
   end

   always @(posedge sda_line) begin
      if (scl_line === 1'b1) begin                  // stop
         in_txn      = 1'b0;
         bit_cnt     = 0;
         selected    = 1'b0;
         tx_active   = 1'b0;
         slv_sda_rel = 1'b1;
      end
   end

   always @(posedge scl_line) begin
      if (bit_cnt < 8) begin
         shreg = {shreg[6:0], sda_line};
         bit_cnt++;
      end else if (bit_cnt == 8) begin
         if (tx_active) begin                       // master ack slot
            m_acked = (sda_line == 1'b0);
            if (m_acked) slv_acks++;
            else slv_nacks++;
         end
         bit_cnt = 9;
      end
   end

   always @(negedge scl_line) begin : slave_drive
      logic ack;
      if (bit_cnt == 8) begin
         if (tx_active) begin
            slv_sda_rel = 1'b1;                     // master answers
         end else begin
            take_byte(shreg, ack);
            slv_sda_rel = !ack;
         end
      end else if (bit_cnt == 9) begin
         bit_cnt     = 0;
         slv_sda_rel = 1'b1;
         if (tx_active && !m_acked) begin
            tx_active = 1'b0;                       // nack ends the read
         end else if (tx_active || (selected && rd_dir && (byte_idx == 1))) begin
            tx_active = 1'b1;
            load_rd_byte();
            slv_sda_rel = tx_data[7];
         end
      end else if (tx_active && (bit_cnt >= 1) && (bit_cnt < 8)) begin
         slv_sda_rel = tx_data[7 - bit_cnt];
      end
   end

   initial begin
      i2c_clk = 1'b0;
      forever #2 i2c_clk = ~i2c_clk;
   end

   always @(posedge i2c_clk) begin
      cycle_cnt++;
      if (cycle_cnt >= TIMEOUT_CYC) begin
         $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
         $display("FAIL: see errors above");
         $finish;
      end
   end

   initial begin : stimulus
      logic rej;
      seed      = 5556;
      i2c_rst_n = 1'b0;
      i_trg     = 1'b0;
      i_dev_id  = 7'h50;
      i_addr16  = 1'b0;
      i_addr    = '0;
      i_num     = '0;
      i_rd      = 1'b0;
      i_wr_data = '0;
      repeat (RST_CYC) @(posedge i2c_clk);
      i2c_rst_n <= 1'b1;
      repeat (3) @(posedge i2c_clk);
      for (int t = 0; t < N_TXN; t++) begin
         rnd        = $random(seed);
         rej        = (rnd[2:0] == 3'd0);            // about one in eight refused
         cur_addr16 = rnd[3];
         rnd        = $random(seed);
         i_trg     <= 1'b1;
         i_rd      <= rnd[16];
         i_addr16  <= cur_addr16;
         i_addr    <= cur_addr16 ? rnd[15:0] : {8'h00, rnd[7:0]};
         i_num     <= `I2CM_NUM_WID'(rnd[18:17]) + 1'b1;
         i_dev_id  <= rej ? (7'h50 ^ {1'b0, rnd[24:20] | 5'h01, 1'b0}) : 7'h50;
         i_wr_data <= rnd[31:24];
         @(posedge i2c_clk);
         i_trg <= 1'b0;
         while (o_done !== 1'b1) begin
            @(posedge i2c_clk);
            if (o_wr_req) begin
               rnd        = $random(seed);
               i_wr_data <= rnd[7:0];                 // next byte for the source
            end
         end
         repeat (GAP_CYC) @(posedge i2c_clk);
      end
      i_checker.print_counts();
      if (err_total == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

// File: testbench/i2cm_checker.sv
// scoreboard of the i2c master testbench
// watches the dut ports and the slave model memory, counts errors
// and prints the count line when the testbench asks for it
`timescale 1ns/1ns
`include "i2cm_settings.svh"

module i2cm_checker (
   input  logic                       i2c_clk,
   input  logic                       i2c_rst_n,
   input  logic                       i_trg,
   input  logic [6:0]                 i_dev_id,
   input  logic                       i_addr16,
   input  logic [`I2CM_ADDR_WID-1:0]  i_addr,
   input  logic [`I2CM_NUM_WID-1:0]   i_num,
   input  logic                       i_rd,
   input  logic [`I2CM_BYTE_BITS-1:0] i_wr_data,
   input  logic                       i_scl_en,
   input  logic                       i_sda_en,
   input  logic                       i_wr_req,
   input  logic [`I2CM_BYTE_BITS-1:0] i_rd_data,
   input  logic                       i_rd_vld,
   input  logic [`I2CM_ADDR_WID-1:0]  i_data_addr,
   input  logic                       i_done,
   input  logic                       i_nack,
   input  int                         i_slv_acks,    // master acks seen by the slave
   input  int                         i_slv_nacks,
   input  int                         i_assert_fails, // from the bound bit engine props
   output int                         o_err_total
);

   int                        mismatch_cnt = 0;
   int                        other_cnt    = 0;
   int                        txn_idx      = 0;
   logic                      idle;
   logic                      seen_trg;
   logic                      cmd_rd;
   logic                      cmd_rej;             // device id the slave refuses
   int                        num_eff;
   int                        cyc;
   int                        lat_max;
   int                        wr_cnt;
   int                        rd_cnt;
   int                        mem_size;
   logic [`I2CM_ADDR_WID-1:0] exp_addr;
   logic [`I2CM_ADDR_WID-1:0] wr_addr_q [$];
   logic [7:0]                wr_data_q [$];
   string                     test_name = "reset";

   assign o_err_total = mismatch_cnt + other_cnt + i_assert_fails;

   task automatic report_mismatch(input string what, input int exp_v, input int act_v);
      mismatch_cnt++;
      $display("MISMATCH %s %s expected %0h actual %0h", test_name, what, exp_v, act_v);
   endtask

   task automatic report_error(input string msg);
      other_cnt++;
      $display("ERROR %s: %s", test_name, msg);
   endtask

   task automatic print_counts();
      $display("checker: %0d transactions, %0d mismatches, %0d other errors, %0d assertion fails",
               txn_idx, mismatch_cnt, other_cnt, i_assert_fails);
   endtask

   // upper bound from start cycle to o_done
   function automatic int latency_limit(input logic rd, input logic a16, input int n);
      int a;
      a = a16 ? 2 : 1;
      return rd ? (3 + a + n) * 37 + 27 : (2 + a + n) * 37 + 18;
   endfunction

   task automatic check_done();
      logic [`I2CM_ADDR_WID-1:0] a;
      logic [7:0]                d;
      int                        exp_wr;
      int                        exp_rd;
      exp_wr = (!cmd_rd && !cmd_rej) ? num_eff : 0;
      exp_rd = (cmd_rd && !cmd_rej) ? num_eff : 0;
      if (i_nack !== cmd_rej) report_mismatch("o_nack", cmd_rej, i_nack);
      if (wr_cnt != exp_wr) report_mismatch("wr_req count", exp_wr, wr_cnt);
      if (rd_cnt != exp_rd) report_mismatch("rd_vld count", exp_rd, rd_cnt);
      if (cyc > lat_max) begin
         report_error($sformatf("o_done after %0d cycles, limit %0d", cyc, lat_max));
      end
      if (exp_rd != 0) begin
         if (i_slv_acks != num_eff - 1) report_mismatch("master acks", num_eff - 1, i_slv_acks);
         if (i_slv_nacks != 1) report_mismatch("master nacks", 1, i_slv_nacks);
      end
      if (cmd_rej && (i2cm_tb.byte_idx != 1)) begin
         report_error($sformatf("refused transaction sent %0d bytes instead of the device byte",
                                i2cm_tb.byte_idx));
      end
      if (cmd_rej && (i2cm_tb.slv_mem.num() != mem_size)) begin
         report_error("slave memory changed by a refused transaction");
      end
      while (wr_addr_q.size() > 0) begin
         a = wr_addr_q.pop_front();
         d = wr_data_q.pop_front();
         if (!i2cm_tb.slv_mem.exists(a)) begin
            report_error($sformatf("write to %h never reached the slave", a));
         end else if (i2cm_tb.slv_mem[a] !== d) begin
            report_mismatch($sformatf("mem[%h]", a), d, i2cm_tb.slv_mem[a]);
         end
      end
   endtask

   always @(posedge i2c_clk) begin
      if (!i2c_rst_n) begin
         idle     = 1'b1;
         seen_trg = 1'b0;
      end else begin
         if (!seen_trg && ((i_scl_en !== 1'b1) || (i_sda_en !== 1'b1) || (i_done !== 1'b0))) begin
            report_error("bus not released or o_done high before first trigger");
         end
         if (!idle) cyc++;
         if (i_wr_req) begin
            if (idle || cmd_rd || cmd_rej) begin
               report_error("unexpected o_wr_req");
            end else begin
               if (i_data_addr !== exp_addr) report_mismatch("write addr", exp_addr, i_data_addr);
               wr_addr_q.push_back(exp_addr);
               wr_data_q.push_back(i_wr_data);   // byte taken in this cycle
            end
            exp_addr++;
            wr_cnt++;
         end
         if (i_rd_vld) begin
            if (idle || !cmd_rd || cmd_rej) begin
               report_error("unexpected o_rd_vld");
            end else if (!i2cm_tb.slv_mem.exists(exp_addr)) begin
               report_error($sformatf("slave never served address %h", exp_addr));
            end else begin
               if (i_data_addr !== exp_addr) report_mismatch("read addr", exp_addr, i_data_addr);
               if (i_rd_data !== i2cm_tb.slv_mem[exp_addr]) begin
                  report_mismatch("read data", i2cm_tb.slv_mem[exp_addr], i_rd_data);
               end
            end
            exp_addr++;
            rd_cnt++;
         end
         if (i_done) begin
            if (idle) begin
               report_error("o_done without a running transaction");
            end else begin
               check_done();
               idle = 1'b1;
               txn_idx++;
            end
         end else if (idle && i_trg) begin
            idle      = 1'b0;
            seen_trg  = 1'b1;
            cmd_rd    = i_rd;
            cmd_rej   = (i_dev_id != 7'h50);
            num_eff   = (i_num == 0) ? 1 : i_num;
            exp_addr  = i_addr;
            cyc       = 0;
            wr_cnt    = 0;
            rd_cnt    = 0;
            lat_max   = latency_limit(i_rd, i_addr16, num_eff);
            mem_size  = i2cm_tb.slv_mem.num();
            test_name = $sformatf("txn%0d_%s", txn_idx, i_rd ? "read" : "write");
         end
      end
   end

endmodule

// File: testbench/i2cm_props.sv
// protocol assertions for the i2c bit engine
// attached to every i2cm_bit_engine instance by a bind in the testbench
`timescale 1ns/1ns

module i2cm_props
   import i2cm_pkg::*;
(
   input logic         i2c_clk,
   input logic         i2c_rst_n,
   input logic         i_scl_en,
   input logic         i_sda_en,
   input logic         i_busy,        // engine is running an op
   input i2cm_bit_op_e i_op,
   input logic         i_op_go,
   input logic         i_op_done
);

   logic shape_op;
   logic in_flight;                   // between op_go and its op_done
   int   fail_cnt = 0;                // failed assertions so far

   assign shape_op = i_busy && ((i_op == OP_START) || (i_op == OP_STOP));

   always_ff @(posedge i2c_clk or negedge i2c_rst_n) begin
      if (!i2c_rst_n) begin
         in_flight <= 1'b0;
      end else if (i_op_go) begin
         in_flight <= 1'b1;
      end else if (i_op_done) begin
         in_flight <= 1'b0;
      end
   end

   // data may only move while scl is pulled low
   sda_while_scl_low: assert property (@(posedge i2c_clk) disable iff (!i2c_rst_n)
      ($changed(i_sda_en) && !shape_op) |-> !i_scl_en)
      else begin
         fail_cnt++;
         $error("sda moved while scl was released");
      end

   done_needs_op: assert property (@(posedge i2c_clk) disable iff (!i2c_rst_n)
      i_op_done |-> in_flight)
      else begin
         fail_cnt++;
         $error("op_done without an operation in flight");
      end

   go_only_when_free: assert property (@(posedge i2c_clk) disable iff (!i2c_rst_n)
      i_op_go |-> !in_flight)
      else begin
         fail_cnt++;
         $error("op_go while an operation is in flight");
      end

endmodule

// File: logic/i2cm_top.sv
// i2c master top, one write or random read per i_trg
// scl/sda are open-drain enables, 1 releases the line
`timescale 1ns/1ns
`include "i2cm_settings.svh"

module i2cm_top
   import i2cm_pkg::*;
(
   input  logic                       i2c_clk,
   input  logic                       i2c_rst_n,
   input  logic                       i_trg,
   input  logic [6:0]                 i_dev_id,
   input  logic                       i_addr16,
   input  logic [`I2CM_ADDR_WID-1:0]  i_addr,
   input  logic [`I2CM_NUM_WID-1:0]   i_num,
   input  logic                       i_rd,
   input  logic [`I2CM_BYTE_BITS-1:0] i_wr_data,
   input  logic                       i_sda,
   output logic                       o_scl_en,
   output logic                       o_sda_en,
   output logic                       o_wr_req,
   output logic [`I2CM_BYTE_BITS-1:0] o_rd_data,
   output logic                       o_rd_vld,
   output logic [`I2CM_ADDR_WID-1:0]  o_data_addr,
   output logic                       o_done,
   output logic                       o_nack
);

   i2cm_bit_op_e op;
   logic         op_go;
   i2cm_byte_t   tx_byte;
   logic         op_done;
   logic         ack_ok;
   logic         rx_bit_stb;
   logic         rx_bit;
   logic         rx_byte_end;
   logic         txn_end;
   logic         nack_seen;

   i2cm_byte_sequencer i_i2cm_byte_sequencer (
      .i2c_clk     (i2c_clk),
      .i2c_rst_n   (i2c_rst_n),
      .i_trg       (i_trg),
      .i_dev_id    (i_dev_id),
      .i_addr16    (i_addr16),
      .i_addr      (i_addr),
      .i_num       (i_num),
      .i_rd        (i_rd),
      .i_wr_data   (i_wr_data),
      .i_op_done   (op_done),
      .i_ack_ok    (ack_ok),
      .o_op        (op),
      .o_op_go     (op_go),
      .o_tx_byte   (tx_byte),
      .o_wr_req    (o_wr_req),
      .o_data_addr (o_data_addr),
      .o_txn_end   (txn_end),
      .o_nack_seen (nack_seen)
   );

   i2cm_bit_engine i_i2cm_bit_engine (
      .i2c_clk       (i2c_clk),
      .i2c_rst_n     (i2c_rst_n),
      .i_op          (op),
      .i_op_go       (op_go),
      .i_tx_byte     (tx_byte),
      .i_sda         (i_sda),
      .o_scl_en      (o_scl_en),
      .o_sda_en      (o_sda_en),
      .o_op_done     (op_done),
      .o_ack_ok      (ack_ok),
      .o_rx_bit_stb  (rx_bit_stb),
      .o_rx_bit      (rx_bit),
      .o_rx_byte_end (rx_byte_end)
   );

   i2cm_read_collect i_i2cm_read_collect (
      .i2c_clk       (i2c_clk),
      .i2c_rst_n     (i2c_rst_n),
      .i_rx_bit_stb  (rx_bit_stb),
      .i_rx_bit      (rx_bit),
      .i_rx_byte_end (rx_byte_end),
      .i_txn_end     (txn_end),
      .i_nack_seen   (nack_seen),
      .o_rd_data     (o_rd_data),
      .o_rd_vld      (o_rd_vld),
      .o_done        (o_done),
      .o_nack        (o_nack)
   );

endmodule

// File: logic/i2cm_read_collect.sv
// read side of the i2c master
// packs sampled bits into bytes and turns the transaction end into done/nack
`timescale 1ns/1ns
`include "i2cm_settings.svh"

module i2cm_read_collect
   import i2cm_pkg::*;
(
   input  logic                       i2c_clk,
   input  logic                       i2c_rst_n,
   input  logic                       i_rx_bit_stb,
   input  logic                       i_rx_bit,
   input  logic                       i_rx_byte_end,   // after the eighth bit
   input  logic                       i_txn_end,
   input  logic                       i_nack_seen,     // level, valid with i_txn_end
   output logic [`I2CM_BYTE_BITS-1:0] o_rd_data,
   output logic                       o_rd_vld,
   output logic                       o_done,
   output logic                       o_nack
);

   i2cm_byte_t rx_shift;

   // msb arrives first
   always_ff @(posedge i2c_clk) begin
      if (i_rx_bit_stb) begin
         rx_shift <= {rx_shift[`I2CM_BYTE_BITS-2:0], i_rx_bit};
      end
   end

   // byte held until the next one completes
   always_ff @(posedge i2c_clk) begin
      if (i_rx_byte_end) begin
         o_rd_data <= rx_shift;
      end
   end

   always_ff @(posedge i2c_clk or negedge i2c_rst_n) begin
      if (!i2c_rst_n) begin
         o_rd_vld <= 1'b0;
         o_done   <= 1'b0;
         o_nack   <= 1'b0;
      end else begin
         o_rd_vld <= i_rx_byte_end;             // one cycle, with o_rd_data
         o_done   <= i_txn_end;
         if (i_txn_end) begin
            o_nack <= i_nack_seen;               // kept until the next done
         end
      end
   end

endmodule

// File: logic/i2cm_bit_engine.sv
// bit level engine of the i2c master
// runs one op per i_op_go: start/stop shapes or a byte with its ack bit,
// scl high in phases 1 and 2, sda sampled at the end of phase 2
`timescale 1ns/1ns
`include "i2cm_settings.svh"

module i2cm_bit_engine
   import i2cm_pkg::*;
(
   input  logic                       i2c_clk,
   input  logic                       i2c_rst_n,
   input  i2cm_bit_op_e               i_op,
   input  logic                       i_op_go,
   input  logic [`I2CM_BYTE_BITS-1:0] i_tx_byte,
   input  logic                       i_sda,
   output logic                       o_scl_en,      // 1 = released
   output logic                       o_sda_en,      // 1 = released
   output logic                       o_op_done,
   output logic                       o_ack_ok,
   output logic                       o_rx_bit_stb,
   output logic                       o_rx_bit,
   output logic                       o_rx_byte_end
);

   logic                         busy;
   i2cm_bit_op_e                 op_q;
   logic [`I2CM_PHASE_WID-1:0]   phase;
   logic [`I2CM_BIT_CNT_WID-1:0] bit_cnt;         // 0..7 data, 8 = ack slot
   i2cm_byte_t                   shift;
   logic                         ack_q;
   logic                         scl_hold;        // line state kept between ops
   logic                         sda_hold;
   logic                         scl_cur;
   logic                         sda_cur;
   logic                         is_byte;
   logic                         is_rx;
   logic                         ack_bit;
   logic                         phase_last;
   logic                         sample;

   assign is_byte    = (op_q == OP_TX_BYTE) || is_rx;
   assign is_rx      = (op_q == OP_RX_ACK) || (op_q == OP_RX_NACK);
   assign ack_bit    = (bit_cnt == `I2CM_BIT_CNT_WID'(`I2CM_BYTE_BITS));
   assign phase_last = &phase;
   assign sample     = (phase == `I2CM_PHASE_WID'(2));   // end of scl high time

   // line shape for the current slot
   always_comb begin
      case (op_q)
         OP_START: begin
            scl_cur = bit_cnt[0] ^ phase[1];     // low, high x4, low
            sda_cur = ~bit_cnt[0];               // falls in the middle of scl high
         end
         OP_STOP: begin
            scl_cur = bit_cnt[0] | phase[1];     // low x2, then high
            sda_cur = bit_cnt[0];                // rises while scl is high
         end
         default: begin
            scl_cur = phase[0] ^ phase[1];
            if (!ack_bit) begin
               sda_cur = (op_q == OP_TX_BYTE) ? shift[`I2CM_BYTE_BITS-1] : 1'b1;
            end else begin
               sda_cur = (op_q != OP_RX_ACK);    // release for slave ack or our nack
            end
         end
      endcase
   end

   assign o_scl_en  = busy ? scl_cur : scl_hold;
   assign o_sda_en  = busy ? sda_cur : sda_hold;
   assign o_op_done = busy && phase_last &&
                      (is_byte ? ack_bit : (bit_cnt == `I2CM_BIT_CNT_WID'(`I2CM_SHORT_LAST)));
   assign o_ack_ok  = ack_q;

   assign o_rx_bit_stb  = busy && is_rx && !ack_bit && sample;
   assign o_rx_bit      = i_sda;
   assign o_rx_byte_end = busy && is_rx && phase_last &&
                          (bit_cnt == `I2CM_BIT_CNT_WID'(`I2CM_BYTE_BITS - 1));

   always_ff @(posedge i2c_clk or negedge i2c_rst_n) begin
      if (!i2c_rst_n) begin
         busy     <= 1'b0;
         op_q     <= OP_STOP;
         phase    <= '0;
         bit_cnt  <= '0;
         ack_q    <= 1'b0;
         scl_hold <= 1'b1;                       // bus idle
         sda_hold <= 1'b1;
      end else if (i_op_go) begin
         busy    <= 1'b1;
         op_q    <= i_op;
         phase   <= '0;
         bit_cnt <= '0;
      end else if (busy) begin
         phase    <= phase + 1'b1;
         scl_hold <= scl_cur;
         sda_hold <= sda_cur;
         if (phase_last) begin
            bit_cnt <= bit_cnt + 1'b1;
         end
         if (ack_bit && sample) begin
            ack_q <= ~i_sda;                     // slave pulls low to ack
         end
         if (o_op_done) begin
            busy <= 1'b0;
         end
      end
   end

   // tx byte, msb first, moves on at the end of every bit
   always_ff @(posedge i2c_clk) begin
      if (i_op_go) begin
         shift <= i_tx_byte;
      end else if (busy && phase_last) begin
         shift <= {shift[`I2CM_BYTE_BITS-2:0], 1'b0};
      end
   end

endmodule

// File: logic/i2cm_byte_sequencer.sv
// transaction fsm of the i2c master
// walks start, device id, address, data and stop, one bit engine op at a time,
// and keeps the register address and the remaining byte count
`timescale 1ns/1ns
`include "i2cm_settings.svh"

module i2cm_byte_sequencer
   import i2cm_pkg::*;
(
   input  logic                       i2c_clk,
   input  logic                       i2c_rst_n,
   input  logic                       i_trg,        // start pulse, only seen in IDLE
   input  logic [6:0]                 i_dev_id,
   input  logic                       i_addr16,     // 0 = 8-bit register address
   input  logic [`I2CM_ADDR_WID-1:0]  i_addr,
   input  logic [`I2CM_NUM_WID-1:0]   i_num,
   input  logic                       i_rd,
   input  logic [`I2CM_BYTE_BITS-1:0] i_wr_data,    // taken when o_wr_req is high
   input  logic                       i_op_done,
   input  logic                       i_ack_ok,     // valid with i_op_done
   output i2cm_bit_op_e               o_op,
   output logic                       o_op_go,
   output logic [`I2CM_BYTE_BITS-1:0] o_tx_byte,
   output logic                       o_wr_req,
   output logic [`I2CM_ADDR_WID-1:0]  o_data_addr,
   output logic                       o_txn_end,
   output logic                       o_nack_seen
);

   i2cm_state_e              state;
   i2cm_state_e              nxt_state;
   logic [6:0]               dev_id_q;
   logic                     addr16_q;
   logic                     rd_q;
   logic [`I2CM_NUM_WID-1:0] rem_cnt;             // bytes still to move, incl. current
   logic                     last_byte;
   logic                     data_byte;
   logic                     tx_nack;

   assign last_byte = (rem_cnt == `I2CM_NUM_WID'(1));
   assign data_byte = (state == WR_DATA) || (state == RD_DATA);
   assign tx_nack   = (o_op == OP_TX_BYTE) && !i_ack_ok;   // only meaningful with op_done

   // op and byte follow the state, the engine latches them on o_op_go
   always_comb begin
      o_op      = OP_STOP;
      o_tx_byte = '0;
      case (state)
         START, RSTART: o_op = OP_START;
         DEV_WR: begin
            o_op      = OP_TX_BYTE;
            o_tx_byte = {dev_id_q, 1'b0};
         end
         DEV_RD: begin
            o_op      = OP_TX_BYTE;
            o_tx_byte = {dev_id_q, 1'b1};
         end
         ADDR_HI: begin
            o_op      = OP_TX_BYTE;
            o_tx_byte = o_data_addr[`I2CM_ADDR_WID-1 -: `I2CM_BYTE_BITS];
         end
         ADDR_LO: begin
            o_op      = OP_TX_BYTE;
            o_tx_byte = o_data_addr[`I2CM_BYTE_BITS-1:0];
         end
         WR_DATA: begin
            o_op      = OP_TX_BYTE;
            o_tx_byte = i_wr_data;                  // sampled in the o_op_go cycle
         end
         RD_DATA: o_op = last_byte ? OP_RX_NACK : OP_RX_ACK;
         default: o_op = OP_STOP;
      endcase
   end

   always_comb begin
      nxt_state = state;
      case (state)
         START:   nxt_state = DEV_WR;
         DEV_WR:  nxt_state = addr16_q ? ADDR_HI : ADDR_LO;
         ADDR_HI: nxt_state = ADDR_LO;
         ADDR_LO: nxt_state = rd_q ? RSTART : WR_DATA;
         WR_DATA: nxt_state = last_byte ? STOP : WR_DATA;
         RSTART:  nxt_state = DEV_RD;
         DEV_RD:  nxt_state = RD_DATA;
         RD_DATA: nxt_state = last_byte ? STOP : RD_DATA;
         default: nxt_state = IDLE;                // STOP ends here
      endcase
      if (tx_nack) begin
         nxt_state = STOP;                         // slave refused a byte
      end
   end

   always_ff @(posedge i2c_clk or negedge i2c_rst_n) begin
      if (!i2c_rst_n) begin
         state       <= IDLE;
         o_op_go     <= 1'b0;
         o_nack_seen <= 1'b0;
         rem_cnt     <= '0;
         o_data_addr <= '0;
      end else begin
         o_op_go <= 1'b0;
         if ((state == IDLE) && i_trg) begin
            state       <= START;
            o_op_go     <= 1'b1;
            o_nack_seen <= 1'b0;
            o_data_addr <= i_addr;
            rem_cnt     <= (i_num == '0) ? `I2CM_NUM_WID'(1) : i_num;
         end else if (i_op_done) begin
            state   <= nxt_state;
            o_op_go <= (nxt_state != IDLE);      // next op one cycle after done
            if (tx_nack) begin
               o_nack_seen <= 1'b1;
            end
            if (data_byte && !tx_nack) begin
               rem_cnt     <= rem_cnt - 1'b1;
               o_data_addr <= o_data_addr + 1'b1;   // next register
            end
         end
      end
   end

   // command fields, held for the whole transaction
   always_ff @(posedge i2c_clk) begin
      if ((state == IDLE) && i_trg) begin
         dev_id_q <= i_dev_id;
         addr16_q <= i_addr16;
         rd_q     <= i_rd;
      end
   end

   assign o_wr_req  = o_op_go && (state == WR_DATA);
   assign o_txn_end = i_op_done && (state == STOP);

endmodule

// File: logic/i2cm_pkg.sv
// shared types of the i2c master
// imported by wildcard in the module header of every rtl file
`include "i2cm_settings.svh"

package i2cm_pkg;

   // byte sequencer states, one per transaction step
   typedef enum logic [3:0] {
      IDLE,      // waiting for i_trg
      START,     // first start condition
      DEV_WR,    // device id, r/w = 0
      ADDR_HI,   // upper address byte, 16-bit mode only
      ADDR_LO,   // lower address byte
      WR_DATA,   // write data bytes
      RSTART,    // repeated start before a read
      DEV_RD,    // device id, r/w = 1
      RD_DATA,   // read data bytes
      STOP       // stop condition, then back to IDLE
   } i2cm_state_e;

   // bit engine operations
   typedef enum logic [2:0] {
      OP_START,    // start or repeated start shape, 8 cycles
      OP_TX_BYTE,  // 8 bits out, slave ack in, 36 cycles
      OP_RX_ACK,   // 8 bits in, master ack
      OP_RX_NACK,  // 8 bits in, master nack (last read byte)
      OP_STOP      // stop shape, 8 cycles
   } i2cm_bit_op_e;

   // one bus byte
   typedef logic [`I2CM_BYTE_BITS-1:0] i2cm_byte_t;

endpackage

// File: include/i2cm_settings.svh
// widths and bit timing of the i2c master
// included by the package, the rtl and the testbench before any use
`ifndef I2CM_SETTINGS_SVH
`define I2CM_SETTINGS_SVH

// byte count port width, i_num of 0 counts as 1
`define I2CM_NUM_WID      5

// bits per byte on the bus, ack bit comes after these
`define I2CM_BYTE_BITS    8

// register address width, 16-bit covers both address modes
`define I2CM_ADDR_WID     16

// scl phase counter width, four i2c_clk cycles per bit
`define I2CM_PHASE_WID    2

// bit counter width, must reach I2CM_BYTE_BITS for the ack bit
`define I2CM_BIT_CNT_WID  4

// index of the last bit slot of OP_START and OP_STOP (two slots, 8 cycles)
`define I2CM_SHORT_LAST   1

`endif
